// ==== bench/rv_core_tb.sv ====
`include "core_consts.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW           = $clog2(`MEM_WORDS);
  localparam int NUM_TESTS    = 6;
  localparam int PROG_WORDS   = 16;
  localparam int RESET_CYCLES = 10;
  localparam int HALT_TIMEOUT = 200;

  logic                clk;
  logic                rst;
  logic                load_we;
  logic [AW-1:0]       load_addr;
  logic [31:0]         load_data;
  logic                halt;
  core_pkg::retire_t   retire;

  string       test_name   [NUM_TESTS];
  logic [31:0] test_prog   [NUM_TESTS][PROG_WORDS];
  int          test_len    [NUM_TESTS];
  logic [31:0] test_exp    [NUM_TESTS];
  int          test_cycles [NUM_TESTS];  // instructions executed before the ebreak

  // retire monitor state, cleared by reset
  logic [31:0] a0_seen;
  logic [31:0] first_pc;
  logic        seen_any;
  int          retire_count;
  int          x0_retires;

  int pass_cnt;
  int fail_cnt;

  rv_core i_dut (
    .clk       (clk),
    .rst       (rst),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .halt      (halt),
    .retire    (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      a0_seen      <= '0;
      first_pc     <= '0;
      seen_any     <= 1'b0;
      retire_count <= 0;
      x0_retires   <= 0;
    end else if (retire.valid) begin
      retire_count <= retire_count + 1;
      if (!seen_any) begin
        seen_any <= 1'b1;
        first_pc <= retire.pc;
      end
      if (retire.rd == 5'd10) a0_seen <= retire.wdata;
      if (retire.rd == 5'd0) x0_retires <= x0_retires + 1;
    end
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                        int rd);
    rv_isa_pkg::inst_u u;
    u.r_fmt.funct7 = f7;
    u.r_fmt.rs2    = rs2[4:0];
    u.r_fmt.rs1    = rs1[4:0];
    u.r_fmt.funct3 = f3;
    u.r_fmt.rd     = rd[4:0];
    u.r_fmt.opcode = rv_isa_pkg::OP_REG;
    return u.word;
  endfunction

  function automatic logic [31:0] enc_i(rv_isa_pkg::opcode_e op, int rd, logic [2:0] f3,
                                        int rs1, int imm);
    rv_isa_pkg::inst_u u;
    u.i_fmt.imm_11_0 = imm[11:0];
    u.i_fmt.rs1      = rs1[4:0];
    u.i_fmt.funct3   = f3;
    u.i_fmt.rd       = rd[4:0];
    u.i_fmt.opcode   = op;
    return u.word;
  endfunction

  function automatic logic [31:0] enc_s(logic [2:0] f3, int rs1, int rs2, int imm);
    rv_isa_pkg::inst_u u;
    u.s_fmt.imm_11_5 = imm[11:5];
    u.s_fmt.rs2      = rs2[4:0];
    u.s_fmt.rs1      = rs1[4:0];
    u.s_fmt.funct3   = f3;
    u.s_fmt.imm_4_0  = imm[4:0];
    u.s_fmt.opcode   = rv_isa_pkg::OP_STORE;
    return u.word;
  endfunction

  function automatic logic [31:0] enc_b(logic [2:0] f3, int rs1, int rs2, int off);
    rv_isa_pkg::inst_u u;
    u.b_fmt.imm_12   = off[12];
    u.b_fmt.imm_10_5 = off[10:5];
    u.b_fmt.rs2      = rs2[4:0];
    u.b_fmt.rs1      = rs1[4:0];
    u.b_fmt.funct3   = f3;
    u.b_fmt.imm_4_1  = off[4:1];
    u.b_fmt.imm_11   = off[11];
    u.b_fmt.opcode   = rv_isa_pkg::OP_BRANCH;
    return u.word;
  endfunction

  function automatic logic [31:0] enc_u(rv_isa_pkg::opcode_e op, int rd, int imm20);
    rv_isa_pkg::inst_u u;
    u.u_fmt.imm_31_12 = imm20[19:0];
    u.u_fmt.rd        = rd[4:0];
    u.u_fmt.opcode    = op;
    return u.word;
  endfunction

  function automatic logic [31:0] enc_j(int rd, int off);
    rv_isa_pkg::inst_u u;
    u.j_fmt.imm_20    = off[20];
    u.j_fmt.imm_10_1  = off[10:1];
    u.j_fmt.imm_11    = off[11];
    u.j_fmt.imm_19_12 = off[19:12];
    u.j_fmt.rd        = rd[4:0];
    u.j_fmt.opcode    = rv_isa_pkg::OP_JAL;
    return u.word;
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return enc_i(rv_isa_pkg::OP_IMM, rd, rv_isa_pkg::F3_ADD, rs1, imm);
  endfunction

  function automatic logic [31:0] add_rr(int rd, int rs1, int rs2);
    return enc_r(7'b0000000, rs2, rs1, rv_isa_pkg::F3_ADD, rd);
  endfunction

  function automatic logic [31:0] sys_priv(int imm);
    return enc_i(rv_isa_pkg::OP_SYSTEM, 0, rv_isa_pkg::F3_PRIV, 0, imm);
  endfunction

  task automatic put(input int t, input logic [31:0] word);
    test_prog[t][test_len[t]] = word;
    test_len[t]++;
  endtask

  task automatic build_table();
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        r_sra;
    logic [31:0]        r_slt;
    logic [31:0]        r_sltu;
    logic [31:0]        w;
    sa = 100;
    sb = -7;
    for (int t = 0; t < NUM_TESTS; t++) test_len[t] = 0;

    test_name[0] = "alu_ops";
    put(0, addi(1, 0, 100));
    put(0, addi(2, 0, -7));
    put(0, enc_r(7'b0100000, 1, 2, rv_isa_pkg::F3_ADD, 3));  // sub
    put(0, enc_i(rv_isa_pkg::OP_IMM, 4, rv_isa_pkg::F3_SLL, 1, 4));
    put(0, enc_i(rv_isa_pkg::OP_IMM, 5, rv_isa_pkg::F3_SR, 2, 32'h401));  // srai 1
    put(0, enc_i(rv_isa_pkg::OP_IMM, 6, rv_isa_pkg::F3_SR, 2, 28));
    put(0, enc_r(7'b0000000, 1, 2, rv_isa_pkg::F3_SLT, 7));
    put(0, enc_r(7'b0000000, 2, 1, rv_isa_pkg::F3_SLTU, 8));
    put(0, add_rr(10, 3, 4));
    for (int r = 5; r <= 8; r++) put(0, add_rr(10, 10, r));
    put(0, sys_priv(1));
    r_sra  = sb >>> 1;
    r_slt  = (sb < sa) ? 32'd1 : 32'd0;
    r_sltu = ($unsigned(sa) < $unsigned(sb)) ? 32'd1 : 32'd0;
    test_exp[0] = (sb - sa) + (sa << 4) + r_sra + ($unsigned(sb) >> 28) + r_slt + r_sltu;
    test_cycles[0] = 13;

    test_name[1] = "lui_auipc";
    put(1, enc_u(rv_isa_pkg::OP_LUI, 1, 32'h12345));
    put(1, addi(1, 1, 32'h678));
    put(1, enc_u(rv_isa_pkg::OP_AUIPC, 2, 32'h10));
    put(1, enc_u(rv_isa_pkg::OP_AUIPC, 3, 0));
    put(1, enc_r(7'b0100000, 3, 2, rv_isa_pkg::F3_ADD, 10));
    put(1, enc_r(7'b0000000, 1, 10, rv_isa_pkg::F3_XOR, 10));
    put(1, sys_priv(1));
    test_exp[1] = ((`RESET_PC + 32'd8 + (32'h10 << 12)) - (`RESET_PC + 32'd12))
                  ^ ((32'h12345 << 12) + 32'h678);
    test_cycles[1] = 6;

    test_name[2] = "load_store";
    put(2, enc_u(rv_isa_pkg::OP_LUI, 5, 32'h80000));
    put(2, enc_u(rv_isa_pkg::OP_LUI, 6, 32'h89abd));
    put(2, addi(6, 6, -529));
    put(2, enc_s(rv_isa_pkg::F3_W, 5, 6, 256));
    put(2, enc_s(rv_isa_pkg::F3_H, 5, 6, 260));
    put(2, enc_s(rv_isa_pkg::F3_B, 5, 6, 263));
    put(2, enc_i(rv_isa_pkg::OP_LOAD, 11, rv_isa_pkg::F3_B, 5, 263));
    put(2, enc_i(rv_isa_pkg::OP_LOAD, 12, rv_isa_pkg::F3_BU, 5, 259));
    put(2, enc_i(rv_isa_pkg::OP_LOAD, 13, rv_isa_pkg::F3_H, 5, 260));
    put(2, enc_i(rv_isa_pkg::OP_LOAD, 14, rv_isa_pkg::F3_HU, 5, 258));
    put(2, enc_i(rv_isa_pkg::OP_LOAD, 15, rv_isa_pkg::F3_W, 5, 256));
    put(2, add_rr(10, 11, 12));
    put(2, add_rr(10, 10, 13));
    put(2, add_rr(10, 10, 14));
    put(2, enc_r(7'b0000000, 15, 10, rv_isa_pkg::F3_XOR, 10));
    put(2, sys_priv(1));
    w = (32'h89abd << 12) - 32'd529;
    test_exp[2] = ({{24{w[7]}}, w[7:0]} + {24'b0, w[31:24]} + {{16{w[15]}}, w[15:0]}
                  + {16'b0, w[31:16]}) ^ w;
    test_cycles[2] = 15;

    test_name[3] = "branch_jump";
    put(3, addi(10, 0, 0));
    put(3, addi(1, 0, 5));
    put(3, enc_b(rv_isa_pkg::F3_BEQ, 1, 0, 8));   // not taken
    put(3, addi(10, 10, 1));
    put(3, enc_b(rv_isa_pkg::F3_BNE, 1, 0, 8));   // taken
    put(3, addi(10, 10, 2));
    put(3, enc_b(rv_isa_pkg::F3_BLT, 0, 1, 8));   // taken
    put(3, addi(10, 10, 4));
    put(3, enc_b(rv_isa_pkg::F3_BGEU, 0, 1, 8));  // not taken
    put(3, addi(10, 10, 8));
    put(3, enc_j(2, 8));
    put(3, addi(10, 10, 16));
    put(3, enc_i(rv_isa_pkg::OP_JALR, 0, 3'b000, 2, 12));
    put(3, addi(10, 10, 32));
    put(3, add_rr(10, 10, 2));  // link of the jal
    put(3, sys_priv(1));
    test_exp[3] = 32'd1 + 32'd8 + (`RESET_PC + 32'd44);
    test_cycles[3] = 11;  // skipped words do not count

    test_name[4] = "ecall_mret";
    put(4, enc_u(rv_isa_pkg::OP_AUIPC, 1, 0));
    put(4, addi(1, 1, 32));  // handler at word 8
    put(4, enc_i(rv_isa_pkg::OP_SYSTEM, 0, rv_isa_pkg::F3_CSRRW, 1, int'(`CSR_MTVEC)));
    put(4, addi(10, 0, 1));
    put(4, sys_priv(0));
    put(4, addi(10, 10, 64));
    put(4, sys_priv(1));
    put(4, addi(10, 10, 256));  // never reached
    put(4, enc_i(rv_isa_pkg::OP_SYSTEM, 11, rv_isa_pkg::F3_CSRRS, 0, int'(`CSR_MCAUSE)));
    put(4, enc_i(rv_isa_pkg::OP_SYSTEM, 12, rv_isa_pkg::F3_CSRRS, 0, int'(`CSR_MEPC)));
    put(4, addi(12, 12, 4));
    put(4, enc_i(rv_isa_pkg::OP_SYSTEM, 0, rv_isa_pkg::F3_CSRRW, 12, int'(`CSR_MEPC)));
    put(4, add_rr(10, 10, 11));
    put(4, add_rr(10, 10, 12));
    put(4, sys_priv(32'h302));
    test_exp[4] = 32'd1 + 32'd11 + (`RESET_PC + 32'd16 + 32'd4) + 32'd64;
    test_cycles[4] = 13;

    test_name[5] = "x0_reset";
    put(5, addi(1, 0, 9));
    put(5, addi(0, 0, 5));
    put(5, add_rr(0, 1, 1));
    put(5, add_rr(10, 0, 1));
    put(5, sys_priv(1));
    test_exp[5] = 32'd9;
    test_cycles[5] = 4;
  endtask

  task automatic run_test(input int t);
    int   cycles;
    int   held_count;
    logic got_halt;
    logic ok;
    ok = 1'b1;
    @(negedge clk);
    rst = 1'b1;
    for (int c = 0; c < RESET_CYCLES; c++) @(negedge clk);
    for (int i = 0; i < PROG_WORDS; i++) begin
      load_we   = 1'b1;
      load_addr = AW'(i);
      load_data = (i < test_len[t]) ? test_prog[t][i] : $urandom;
      @(negedge clk);
    end
    load_we = 1'b0;
    rst     = 1'b0;

    cycles   = 0;
    got_halt = 1'b0;
    while (!got_halt && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (halt) got_halt = 1'b1;
    end

    assert (got_halt) else begin
      $display("test %s: halt never reached within %0d cycles", test_name[t], HALT_TIMEOUT);
      ok = 1'b0;
    end
    if (got_halt) begin
      assert (cycles == test_cycles[t]) else begin
        $display("Error: time %0t, halt cycle expected %0d, got %0d", $time,
                 test_cycles[t], cycles);
        ok = 1'b0;
      end
      held_count = retire_count;
      repeat (2) @(negedge clk);
      assert (halt && retire_count == held_count) else begin
        $display("test %s: core kept running after EBREAK", test_name[t]);
        ok = 1'b0;
      end
      assert (first_pc == `RESET_PC) else begin
        $display("Error: time %0t, retire.pc expected %h, got %h", $time, `RESET_PC, first_pc);
        ok = 1'b0;
      end
      assert (x0_retires == 0) else begin
        $display("test %s: a write to x0 showed on retire", test_name[t]);
        ok = 1'b0;
      end
      assert (a0_seen == test_exp[t]) else begin
        $display("Error: time %0t, a0 expected %h, got %h", $time, test_exp[t], a0_seen);
        ok = 1'b0;
      end
    end

    if (ok) begin
      pass_cnt++;
      $display("test %s: ok after %0d cycles", test_name[t], cycles);
    end else begin
      fail_cnt++;
      $display("test %s: FAILED", test_name[t]);
    end
  endtask

  initial begin
    rst       = 1'b1;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    void'($urandom(32'hff9a7909));
    build_table();
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== design/alu.sv ====
module alu (
  input  core_pkg::alu_op_e op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output logic [31:0]       result
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      core_pkg::ALU_ADD:    result = a + b;
      core_pkg::ALU_SUB:    result = a - b;
      core_pkg::ALU_SLL:    result = a << shamt;
      core_pkg::ALU_SLT:    result = {31'b0, lt_s};
      core_pkg::ALU_SLTU:   result = {31'b0, lt_u};
      core_pkg::ALU_XOR:    result = a ^ b;
      core_pkg::ALU_SRL:    result = a >> shamt;
      core_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      core_pkg::ALU_OR:     result = a | b;
      core_pkg::ALU_AND:    result = a & b;
      core_pkg::ALU_PASS_B: result = b;
      core_pkg::ALU_EQ:     result = {31'b0, a == b};
      core_pkg::ALU_NE:     result = {31'b0, a != b};
      core_pkg::ALU_GE:     result = {31'b0, ~lt_s};
      core_pkg::ALU_GEU:    result = {31'b0, ~lt_u};
      default:              result = '0;
    endcase
  end

endmodule

// ==== design/core_pkg.sv ====
package core_pkg;

  // slt/sltu also serve blt/bltu
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,
    ALU_EQ,
    ALU_NE,
    ALU_GE,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [2:0] {
    NPC_SNPC,
    NPC_BRANCH,  // pc + imm
    NPC_JALR,
    NPC_TRAP,    // mtvec
    NPC_MEPC
  } npc_sel_e;

  typedef enum logic [2:0] {
    WB_ALU,
    WB_SNPC,
    WB_LOAD,
    WB_CSR
  } wb_sel_e;

  typedef enum logic [1:0] {
    OPB_RS2,
    OPB_IMM,
    OPB_CSR
  } opb_sel_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      opa_pc;
    opb_sel_e  opb_sel;
    npc_sel_e  npc_sel;
    logic      branch;     // npc gated by alu compare
    wb_sel_e   wb_sel;
    logic      reg_we;
    logic      mem_re;
    logic      mem_we;
    mem_size_e mem_size;
    logic      load_sext;
    logic      csr_we;
    logic      csr_set;    // csrrs, or-in rs1
    logic      ecall;
    logic      mret;
    logic      halt;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] wdata;
  } retire_t;

endpackage

// ==== design/decoder.sv ====
module decoder (
  input  logic [31:0]     inst,
  output core_pkg::ctrl_t ctrl,
  output logic [31:0]     imm,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd
);

  rv_isa_pkg::inst_u iw;
  logic [2:0]        f3;
  logic              alt;  // funct7 bit 5

  assign iw  = inst;
  assign f3  = iw.r_fmt.funct3;
  assign alt = iw.r_fmt.funct7[5];
  assign rs1 = iw.r_fmt.rs1;
  assign rs2 = iw.r_fmt.rs2;
  assign rd  = iw.r_fmt.rd;

  function automatic core_pkg::alu_op_e f3_alu_op(input logic [2:0] code, input logic sub_sra);
    case (code)
      rv_isa_pkg::F3_ADD:  return sub_sra ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  return core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  return core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: return core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  return core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   return sub_sra ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   return core_pkg::ALU_OR;
      default:             return core_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;  // no-op, falls through to pc+4
    imm  = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};

    case (iw.r_fmt.opcode)
      rv_isa_pkg::OP_LUI: begin
        imm          = {iw.u_fmt.imm_31_12, 12'b0};
        ctrl.alu_op  = core_pkg::ALU_PASS_B;
        ctrl.opb_sel = core_pkg::OPB_IMM;
        ctrl.reg_we  = 1'b1;
      end
      rv_isa_pkg::OP_AUIPC: begin
        imm          = {iw.u_fmt.imm_31_12, 12'b0};
        ctrl.opa_pc  = 1'b1;
        ctrl.opb_sel = core_pkg::OPB_IMM;
        ctrl.reg_we  = 1'b1;
      end
      rv_isa_pkg::OP_JAL: begin
        imm = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
               iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};
        ctrl.npc_sel = core_pkg::NPC_BRANCH;
        ctrl.wb_sel  = core_pkg::WB_SNPC;
        ctrl.reg_we  = 1'b1;
      end
      rv_isa_pkg::OP_JALR: begin
        ctrl.opb_sel = core_pkg::OPB_IMM;
        ctrl.npc_sel = core_pkg::NPC_JALR;
        ctrl.wb_sel  = core_pkg::WB_SNPC;
        ctrl.reg_we  = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
               iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
        ctrl.npc_sel = core_pkg::NPC_BRANCH;
        ctrl.branch  = 1'b1;
        case (f3)
          rv_isa_pkg::F3_BEQ:  ctrl.alu_op = core_pkg::ALU_EQ;
          rv_isa_pkg::F3_BNE:  ctrl.alu_op = core_pkg::ALU_NE;
          rv_isa_pkg::F3_BLT:  ctrl.alu_op = core_pkg::ALU_SLT;
          rv_isa_pkg::F3_BGE:  ctrl.alu_op = core_pkg::ALU_GE;
          rv_isa_pkg::F3_BLTU: ctrl.alu_op = core_pkg::ALU_SLTU;
          rv_isa_pkg::F3_BGEU: ctrl.alu_op = core_pkg::ALU_GEU;
          default: begin
            ctrl.npc_sel = core_pkg::NPC_SNPC;
            ctrl.branch  = 1'b0;
          end
        endcase
      end
      rv_isa_pkg::OP_LOAD: begin
        if (f3[1:0] != 2'b11 && f3 != 3'b110) begin
          ctrl.opb_sel   = core_pkg::OPB_IMM;
          ctrl.wb_sel    = core_pkg::WB_LOAD;
          ctrl.reg_we    = 1'b1;
          ctrl.mem_re    = 1'b1;
          ctrl.mem_size  = core_pkg::mem_size_e'(f3[1:0]);
          ctrl.load_sext = ~f3[2];
        end
      end
      rv_isa_pkg::OP_STORE: begin
        imm = {{20{iw.s_fmt.imm_11_5[6]}}, iw.s_fmt.imm_11_5, iw.s_fmt.imm_4_0};
        if (f3 <= rv_isa_pkg::F3_W) begin
          ctrl.opb_sel  = core_pkg::OPB_IMM;
          ctrl.mem_we   = 1'b1;
          ctrl.mem_size = core_pkg::mem_size_e'(f3[1:0]);
        end
      end
      rv_isa_pkg::OP_IMM: begin
        ctrl.alu_op  = f3_alu_op(f3, alt && f3 == rv_isa_pkg::F3_SR);  // no subi
        ctrl.opb_sel = core_pkg::OPB_IMM;
        ctrl.reg_we  = 1'b1;
      end
      rv_isa_pkg::OP_REG: begin
        ctrl.alu_op = f3_alu_op(f3, alt);
        ctrl.reg_we = 1'b1;
      end
      rv_isa_pkg::OP_MISC_MEM: ;  // fence, nothing to order
      rv_isa_pkg::OP_SYSTEM: begin
        case (f3)
          rv_isa_pkg::F3_CSRRW: begin
            ctrl.wb_sel = core_pkg::WB_CSR;
            ctrl.reg_we = 1'b1;
            ctrl.csr_we = 1'b1;
          end
          rv_isa_pkg::F3_CSRRS: begin
            ctrl.alu_op  = core_pkg::ALU_OR;
            ctrl.opb_sel = core_pkg::OPB_CSR;
            ctrl.wb_sel  = core_pkg::WB_CSR;
            ctrl.reg_we  = 1'b1;
            ctrl.csr_we  = 1'b1;
            ctrl.csr_set = 1'b1;
          end
          rv_isa_pkg::F3_PRIV: begin
            if (iw.i_fmt.imm_11_0 == rv_isa_pkg::IMM_ECALL) begin
              ctrl.ecall   = 1'b1;
              ctrl.npc_sel = core_pkg::NPC_TRAP;
            end else if (iw.i_fmt.imm_11_0 == rv_isa_pkg::IMM_MRET) begin
              ctrl.mret    = 1'b1;
              ctrl.npc_sel = core_pkg::NPC_MEPC;
            end else if (iw.i_fmt.imm_11_0 == rv_isa_pkg::IMM_EBREAK) begin
              ctrl.halt = 1'b1;
            end
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// ==== design/reg_heap.sv ====
`include "core_consts.svh"

module reg_heap (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  input  logic [11:0] csr_addr,
  input  logic        csr_wen,
  input  logic [31:0] csr_wdata,
  input  logic        trap_wen,
  input  logic [31:0] trap_cause,
  input  logic [31:0] trap_epc,
  output logic [31:0] src1,
  output logic [31:0] src2,
  output logic [31:0] csr_rdata
);

  logic [31:0] gpr [1:31];
  logic [31:0] mtvec, mepc, mcause, mstatus;

  assign src1 = (rs1 == 5'd0) ? 32'd0 : gpr[rs1];
  assign src2 = (rs2 == 5'd0) ? 32'd0 : gpr[rs2];

  always_comb begin
    case (csr_addr)
      `CSR_MTVEC:   csr_rdata = mtvec;
      `CSR_MEPC:    csr_rdata = mepc;
      `CSR_MCAUSE:  csr_rdata = mcause;
      `CSR_MSTATUS: csr_rdata = mstatus;
      default:      csr_rdata = '0;  // unimplemented csr
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      gpr[rd] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
      mstatus <= '0;
    end else begin
      if (csr_wen) begin
        case (csr_addr)
          `CSR_MTVEC:   mtvec   <= csr_wdata;
          `CSR_MEPC:    mepc    <= csr_wdata;
          `CSR_MCAUSE:  mcause  <= csr_wdata;
          `CSR_MSTATUS: mstatus <= csr_wdata;
          default: ;
        endcase
      end
      if (trap_wen) begin  // trap wins over a csr write
        mcause <= trap_cause;
        mepc   <= trap_epc;
      end
    end
  end

endmodule

// ==== design/rv_core.sv ====
`include "core_consts.svh"

module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load_we,
  input  logic [$clog2(`MEM_WORDS)-1:0] load_addr,
  input  logic [31:0]                   load_data,
  output logic                          halt,
  output core_pkg::retire_t             retire
);

  logic [31:0]     pc, npc, snpc, br_target;
  logic [31:0]     inst, imm;
  logic [4:0]      rs1, rs2, rd;
  core_pkg::ctrl_t ctrl;
  logic [31:0]     src1, src2;
  logic [11:0]     csr_addr;
  logic [31:0]     csr_rdata, csr_wdata;
  logic [31:0]     alu_a, alu_b, alu_result;
  logic [31:0]     mem_rdata, wb_data;
  logic            live;  // this instruction commits at the edge

  assign halt      = ctrl.halt;
  assign live      = !rst && !halt;
  assign snpc      = pc + 32'd4;
  assign br_target = pc + imm;

  always_ff @(posedge clk) begin
    if (rst) pc <= `RESET_PC;
    else if (!halt) pc <= npc;
  end

  always_comb begin
    case (ctrl.npc_sel)
      core_pkg::NPC_BRANCH: npc = (ctrl.branch && !alu_result[0]) ? snpc : br_target;
      core_pkg::NPC_JALR:   npc = {alu_result[31:1], 1'b0};
      core_pkg::NPC_TRAP,
      core_pkg::NPC_MEPC:   npc = csr_rdata;  // csr_addr already points there
      default:              npc = snpc;
    endcase
  end

  assign csr_addr  = ctrl.ecall ? `CSR_MTVEC : ctrl.mret ? `CSR_MEPC : imm[11:0];
  assign csr_wdata = ctrl.csr_set ? alu_result : src1;

  assign alu_a = ctrl.opa_pc ? pc : src1;

  always_comb begin
    case (ctrl.opb_sel)
      core_pkg::OPB_IMM: alu_b = imm;
      core_pkg::OPB_CSR: alu_b = csr_rdata;
      default:           alu_b = src2;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::WB_SNPC: wb_data = snpc;
      core_pkg::WB_LOAD: wb_data = mem_rdata;
      core_pkg::WB_CSR:  wb_data = csr_rdata;  // old value
      default:           wb_data = alu_result;
    endcase
  end

  assign retire.valid = live && ctrl.reg_we && rd != 5'd0;
  assign retire.pc    = pc;
  assign retire.rd    = rd;
  assign retire.wdata = wb_data;

  decoder i_decoder (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  reg_heap i_reg_heap (
    .clk        (clk),
    .rst        (rst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .wen        (live && ctrl.reg_we),
    .wdata      (wb_data),
    .csr_addr   (csr_addr),
    .csr_wen    (live && ctrl.csr_we),
    .csr_wdata  (csr_wdata),
    .trap_wen   (live && ctrl.ecall),
    .trap_cause (`CAUSE_ECALL_M),
    .trap_epc   (pc),
    .src1       (src1),
    .src2       (src2),
    .csr_rdata  (csr_rdata)
  );

  alu i_alu (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  unified_mem i_mem (
    .clk        (clk),
    .fetch_addr (pc),
    .addr       (alu_result),
    .ren        (ctrl.mem_re),
    .wen        (live && ctrl.mem_we),
    .size       (ctrl.mem_size),
    .sext       (ctrl.load_sext),
    .wdata      (src2),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .inst       (inst),
    .rdata      (mem_rdata)
  );

endmodule

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_AUIPC    = 7'b0010111,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_IMM      = 7'b0010011,
    OP_REG      = 7'b0110011,
    OP_MISC_MEM = 7'b0001111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // alu funct3 for OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra by funct7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load/store width, bit 2 set means zero extend
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // system funct3
  localparam logic [2:0] F3_PRIV  = 3'b000;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  // imm field of the privileged system instructions
  localparam logic [11:0] IMM_ECALL  = 12'h000;
  localparam logic [11:0] IMM_EBREAK = 12'h001;
  localparam logic [11:0] IMM_MRET   = 12'h302;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    logic [31:0] word;
    r_fmt_t      r_fmt;
    i_fmt_t      i_fmt;
    s_fmt_t      s_fmt;
    b_fmt_t      b_fmt;
    u_fmt_t      u_fmt;
    j_fmt_t      j_fmt;
  } inst_u;

endpackage

// ==== design/unified_mem.sv ====
`include "core_consts.svh"

module unified_mem (
  input  logic                           clk,
  input  logic [31:0]                    fetch_addr,
  input  logic [31:0]                    addr,
  input  logic                           ren,
  input  logic                           wen,
  input  core_pkg::mem_size_e            size,
  input  logic                           sext,
  input  logic [31:0]                    wdata,
  input  logic                           load_we,
  input  logic [$clog2(`MEM_WORDS)-1:0]  load_addr,
  input  logic [31:0]                    load_data,
  output logic [31:0]                    inst,
  output logic [31:0]                    rdata
);

  localparam int AW = $clog2(`MEM_WORDS);

  logic [31:0]   mem [`MEM_WORDS];
  logic [31:0]   fetch_off, data_off;
  logic [AW-1:0] fetch_idx, data_idx;
  logic [31:0]   rd_word;
  logic [7:0]    lane_b;
  logic [15:0]   lane_h;

  // offset from the reset pc, wraps at the memory depth
  assign fetch_off = fetch_addr - `RESET_PC;
  assign data_off  = addr - `RESET_PC;
  assign fetch_idx = fetch_off[AW+1:2];
  assign data_idx  = data_off[AW+1:2];

  assign inst = mem[fetch_idx];

  assign rd_word = mem[data_idx];
  assign lane_b  = rd_word[{addr[1:0], 3'b000} +: 8];
  assign lane_h  = addr[1] ? rd_word[31:16] : rd_word[15:0];

  always_comb begin
    case (size)
      core_pkg::SIZE_BYTE: rdata = {{24{sext & lane_b[7]}}, lane_b};
      core_pkg::SIZE_HALF: rdata = {{16{sext & lane_h[15]}}, lane_h};
      default:             rdata = rd_word;
    endcase
    if (!ren) rdata = '0;
  end

  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data;  // program load
    end else if (wen) begin
      case (size)
        core_pkg::SIZE_BYTE: mem[data_idx][{addr[1:0], 3'b000} +: 8] <= wdata[7:0];
        core_pkg::SIZE_HALF: mem[data_idx][{addr[1], 4'b0000} +: 16] <= wdata[15:0];
        default:             mem[data_idx] <= wdata;
      endcase
    end
  end

endmodule

// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define RESET_PC 32'h8000_0000

// depth of the unified memory in 32-bit words
`define MEM_WORDS 1024

// machine-mode csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

`define CAUSE_ECALL_M 32'd11  // environment call from m-mode

`endif

// ==== run.sh ====
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f tb.f --top-module rv_core_tb; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vrv_core_tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0

// ==== tb.f ====
+incdir+include
design/rv_isa_pkg.sv
design/core_pkg.sv
design/alu.sv
design/decoder.sv
design/reg_heap.sv
design/unified_mem.sv
design/rv_core.sv
bench/rv_core_tb.sv
